// File: pool_cfg_pkg.sv
// Pool geometry constants with index, neighbor-count and channel-count types
package pool_cfg_pkg;

    // ==============================
    // Geometry
    // ==============================

    // One GLB row address, also one neighbor index
    parameter int IDX_WIDTH = 10;

    // Most neighbors gathered per point
    parameter int MAX_K = 8;

    // Holds 0..MAX_K inclusive
    parameter int K_WIDTH = $clog2(MAX_K + 1);

    // Raw channel count, before grouping into lanes
    parameter int CHN_WIDTH = 12;

    // ==============================
    // Types
    // ==============================

    // Row addresses, neighbor indices, point and group counts
    typedef logic [IDX_WIDTH-1:0] pool_idx_t;

    // Neighbors per point from the host
    typedef logic [K_WIDTH-1:0] pool_k_t;

    // Channels per point from the host
    typedef logic [CHN_WIDTH-1:0] pool_chn_t;

endpackage

// File: pool_data_pkg.sv
// Activation lane types, feature word type and neighbor-map word union
package pool_data_pkg;

    import pool_cfg_pkg::*;

    // ==============================
    // Feature data
    // ==============================

    // Unsigned activation
    parameter int ACT_WIDTH = 8;

    // Lanes per GLB feature word
    parameter int NUM_CH = 16;

    typedef logic [ACT_WIDTH-1:0] act_t;

    // One channel group of one point, lane 0 in the low byte
    typedef act_t [NUM_CH-1:0] act_vec_t;

    // ==============================
    // Neighbor map
    // ==============================

    // One GLB map row carries all neighbors of a point
    parameter int MAP_WIDTH = MAX_K * IDX_WIDTH;

    // Same bits seen as a GLB row or as neighbor slots, slot 0 lowest
    typedef union packed {
        logic [MAP_WIDTH-1:0]  raw;
        pool_idx_t [MAX_K-1:0] nbr;
    } map_word_u;

endpackage

// File: pool_if.sv
// Job configuration interface and neighbor index stream interface with modports

// ==============================
// Latched job configuration
// ==============================
interface pool_cfg_if
    import pool_cfg_pkg::*;
();

    // One-cycle pulse in the first cycle of a job
    logic      start;
    // Neighbors per point
    pool_k_t   k;
    // Points in the job
    pool_idx_t nip;
    // Channel groups per point
    pool_idx_t chg;
    // One-cycle pulse on the last accepted write
    logic      done;

    modport cfg_src (
        output start, k, nip, chg,
        input  done
    );

    modport cfg_sink (
        input  start, k, nip, chg,
        output done
    );

endinterface

// ==============================
// Neighbor index stream
// ==============================
interface pool_idx_if
    import pool_cfg_pkg::*;
();

    logic      vld;
    logic      rdy;
    // Neighbor point index
    pool_idx_t idx;
    // Channel group of this item
    pool_idx_t grp;

    modport src (
        output vld, idx, grp,
        input  rdy
    );

    modport sink (
        input  vld, idx, grp,
        output rdy
    );

endinterface

// File: pool_map_fetch.sv
// Job FSM, configuration latch, map-word requests and neighbor index stream
module pool_map_fetch
    import pool_cfg_pkg::*;
    import pool_data_pkg::*;
#(
    parameter int IDX_W  = pool_cfg_pkg::IDX_WIDTH,
    parameter int MAX_K  = pool_cfg_pkg::MAX_K,
    parameter int NUM_CH = pool_data_pkg::NUM_CH
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         clr,
    // Host configuration
    input  logic         cfg_vld,
    input  pool_k_t      cfg_k,
    input  pool_idx_t    cfg_nip,
    input  pool_chn_t    cfg_chi,
    output logic         cfg_rdy,
    // GLB map read address
    output logic         map_rd_addr_vld,
    output pool_idx_t    map_rd_addr,
    input  logic         map_rd_addr_rdy,
    // GLB map read data
    input  logic         map_rd_vld,
    input  map_word_u    map_rd_dat,
    output logic         map_rd_rdy,
    pool_cfg_if.cfg_src  cfg,
    pool_idx_if.src      idx
);

    localparam int KC_W = $clog2(MAX_K + 1);

    localparam logic [1:0] IDLE    = 2'b00;
    localparam logic [1:0] MAPIN   = 2'b01;
    localparam logic [1:0] WAITFNH = 2'b11;

    logic [1:0]       state;
    logic [1:0]       next_state;
    logic             cfg_hs;
    logic [IDX_W-1:0] req_cnt;
    logic             req_hs;
    logic             req_last;
    map_word_u        word_q;
    logic             word_vld;
    logic             map_hs;
    logic [IDX_W-1:0] grp_cnt;
    logic [KC_W-1:0]  nbr_cnt;
    logic             idx_hs;
    logic             nbr_last;
    logic             grp_last;

    // ==============================
    // Job FSM
    // ==============================
    assign cfg_rdy = (state == IDLE);
    assign cfg_hs  = cfg_vld && cfg_rdy;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (cfg_hs) begin
                    next_state = MAPIN;
                end
            end
            // Leave once the last point's map row is requested
            MAPIN: begin
                if (req_hs && req_last) begin
                    next_state = WAITFNH;
                end
            end
            // Pipeline drains, core reports the last write
            WAITFNH: begin
                if (cfg.done) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (clr) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Job parameters, group count is channels over lanes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.start <= 1'b0;
            cfg.k     <= '0;
            cfg.nip   <= '0;
            cfg.chg   <= '0;
        end else if (clr) begin
            cfg.start <= 1'b0;
        end else begin
            cfg.start <= cfg_hs;
            if (cfg_hs) begin
                cfg.k   <= cfg_k;
                cfg.nip <= cfg_nip;
                cfg.chg <= IDX_W'(cfg_chi / NUM_CH);
            end
        end
    end

    // ==============================
    // Map row requests
    // ==============================
    assign map_rd_addr_vld = (state == MAPIN);
    assign map_rd_addr     = req_cnt;
    assign req_hs          = map_rd_addr_vld && map_rd_addr_rdy;
    assign req_last        = (req_cnt == IDX_W'(cfg.nip - 1'b1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_cnt <= '0;
        end else if (clr || cfg_hs) begin
            req_cnt <= '0;
        end else if (req_hs && !req_last) begin
            req_cnt <= req_cnt + 1'b1;
        end
    end

    // ==============================
    // Index stream, group outer, neighbor inner
    // ==============================
    // One map row in flight, next one waits at the GLB
    assign map_rd_rdy = !word_vld;
    assign map_hs     = map_rd_vld && map_rd_rdy;

    always_ff @(posedge clk) begin
        if (map_hs) begin
            word_q.raw <= map_rd_dat.raw;
        end
    end

    assign idx.vld  = word_vld;
    assign idx.idx  = word_q.nbr[nbr_cnt];
    assign idx.grp  = grp_cnt;
    assign idx_hs   = idx.vld && idx.rdy;
    assign nbr_last = (nbr_cnt == KC_W'(cfg.k - 1'b1));
    assign grp_last = (grp_cnt == IDX_W'(cfg.chg - 1'b1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_vld <= 1'b0;
            grp_cnt  <= '0;
            nbr_cnt  <= '0;
        end else if (clr) begin
            word_vld <= 1'b0;
            grp_cnt  <= '0;
            nbr_cnt  <= '0;
        end else if (map_hs) begin
            word_vld <= 1'b1;
            grp_cnt  <= '0;
            nbr_cnt  <= '0;
        end else if (idx_hs) begin
            if (!nbr_last) begin
                nbr_cnt <= nbr_cnt + 1'b1;
            end else begin
                nbr_cnt <= '0;
                // Row done after the last group
                if (grp_last) begin
                    word_vld <= 1'b0;
                end else begin
                    grp_cnt <= grp_cnt + 1'b1;
                end
            end
        end
    end

    // Neighbor count must fit the map row
    assert property (@(posedge clk) disable iff (!rst_n)
        cfg_hs |-> (cfg_k != '0) && (cfg_k <= MAX_K));

endmodule

// File: pool_ofm_gather.sv
// Feature row address generation and registered GLB feature read request
module pool_ofm_gather
    import pool_cfg_pkg::*;
#(
    parameter int IDX_W = pool_cfg_pkg::IDX_WIDTH
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clr,
    pool_cfg_if.cfg_sink  cfg,
    pool_idx_if.sink      idx,
    // GLB feature read address
    output logic          ofm_rd_addr_vld,
    output pool_idx_t     ofm_rd_addr,
    input  logic          ofm_rd_addr_rdy
);

    logic [IDX_W-1:0] row_addr;
    logic             idx_hs;
    logic             req_vld;
    logic [IDX_W-1:0] req_addr;
    logic             req_hs;

    // ==============================
    // Row address
    // ==============================
    // Feature rows of a point sit together, one row per group
    assign row_addr = idx.idx * cfg.chg + idx.grp;

    // ==============================
    // Request register
    // ==============================
    // Take a new index when empty or emptying this cycle
    assign req_hs  = req_vld && ofm_rd_addr_rdy;
    assign idx.rdy = !req_vld || ofm_rd_addr_rdy;
    assign idx_hs  = idx.vld && idx.rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_vld <= 1'b0;
        end else if (clr) begin
            req_vld <= 1'b0;
        end else if (idx_hs) begin
            req_vld <= 1'b1;
        end else if (req_hs) begin
            req_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (idx_hs) begin
            req_addr <= row_addr;
        end
    end

    assign ofm_rd_addr_vld = req_vld;
    assign ofm_rd_addr     = req_addr;

    // Stalled request held unchanged for the GLB
    assert property (@(posedge clk) disable iff (!rst_n)
        ofm_rd_addr_vld && !ofm_rd_addr_rdy && !clr
        |=> ofm_rd_addr_vld && $stable(ofm_rd_addr));

endmodule

// File: pool_max_core.sv
// Lane-wise running maximum, pooled write register, write address and job done
module pool_max_core
    import pool_cfg_pkg::*;
    import pool_data_pkg::*;
#(
    parameter int IDX_W  = pool_cfg_pkg::IDX_WIDTH,
    parameter int MAX_K  = pool_cfg_pkg::MAX_K,
    parameter int NUM_CH = pool_data_pkg::NUM_CH
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clr,
    pool_cfg_if.cfg_sink  cfg,
    // GLB feature read data
    input  logic          ofm_rd_vld,
    input  act_vec_t      ofm_rd_dat,
    output logic          ofm_rd_rdy,
    // GLB pooled write
    output logic          ofm_wr_vld,
    output pool_idx_t     ofm_wr_addr,
    output act_vec_t      ofm_wr_dat,
    input  logic          ofm_wr_rdy
);

    localparam int KC_W = $clog2(MAX_K + 1);

    logic [KC_W-1:0]  beat_cnt;
    logic             beat_first;
    logic             beat_last;
    logic             rd_hs;
    act_vec_t         merged;
    act_vec_t         acc;
    logic             res_vld;
    logic [IDX_W-1:0] wr_cnt;
    logic [IDX_W-1:0] wr_total;
    logic             wr_hs;
    logic             wr_last;

    // ==============================
    // Beat accumulation
    // ==============================
    // No new beats while a result waits for the GLB
    assign ofm_rd_rdy = !res_vld;
    assign rd_hs      = ofm_rd_vld && ofm_rd_rdy;
    assign beat_first = (beat_cnt == '0);
    assign beat_last  = (beat_cnt == KC_W'(cfg.k - 1'b1));

    // First beat loads, later beats keep the larger lane
    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            if (beat_first || (ofm_rd_dat[i] > acc[i])) begin
                merged[i] = ofm_rd_dat[i];
            end else begin
                merged[i] = acc[i];
            end
        end
    end

    // Running maxima, doubles as the write data register
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            acc <= merged;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            res_vld  <= 1'b0;
        end else if (clr || cfg.start) begin
            beat_cnt <= '0;
            res_vld  <= 1'b0;
        end else if (rd_hs) begin
            if (beat_last) begin
                beat_cnt <= '0;
                res_vld  <= 1'b1;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end else if (wr_hs) begin
            res_vld <= 1'b0;
        end
    end

    // ==============================
    // Write-back and completion
    // ==============================
    // Points times groups, writes go out in address order
    assign wr_total = IDX_W'(cfg.nip * cfg.chg);
    assign wr_hs    = ofm_wr_vld && ofm_wr_rdy;
    assign wr_last  = (wr_cnt == IDX_W'(wr_total - 1'b1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt <= '0;
        end else if (clr || cfg.start) begin
            wr_cnt <= '0;
        end else if (wr_hs) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    assign ofm_wr_vld  = res_vld;
    assign ofm_wr_addr = wr_cnt;
    assign ofm_wr_dat  = acc;

    // Same cycle as the last accepted write
    assign cfg.done = wr_hs && wr_last;

    // Pending write keeps its address and data
    assert property (@(posedge clk) disable iff (!rst_n)
        ofm_wr_vld && !ofm_wr_rdy && !clr
        |=> ofm_wr_vld && $stable(ofm_wr_dat) && $stable(ofm_wr_addr));

endmodule

// File: pool_top.sv
// Max-pooling unit top level joining map fetch, feature gather and max core to GLB ports
module pool_top
    import pool_cfg_pkg::*;
    import pool_data_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clr,
    // Host configuration
    input  logic       cfg_vld,
    output logic       cfg_rdy,
    input  pool_k_t    cfg_k,
    input  pool_idx_t  cfg_nip,
    input  pool_chn_t  cfg_chi,
    // GLB map read
    output logic       map_rd_addr_vld,
    output pool_idx_t  map_rd_addr,
    input  logic       map_rd_addr_rdy,
    input  logic       map_rd_vld,
    input  map_word_u  map_rd_dat,
    output logic       map_rd_rdy,
    // GLB feature read
    output logic       ofm_rd_addr_vld,
    output pool_idx_t  ofm_rd_addr,
    input  logic       ofm_rd_addr_rdy,
    input  logic       ofm_rd_vld,
    input  act_vec_t   ofm_rd_dat,
    output logic       ofm_rd_rdy,
    // GLB pooled write
    output logic       ofm_wr_vld,
    output pool_idx_t  ofm_wr_addr,
    output act_vec_t   ofm_wr_dat,
    input  logic       ofm_wr_rdy
);

    // Block geometry from the package defaults
    localparam int IDX_W  = pool_cfg_pkg::IDX_WIDTH;
    localparam int MAX_K  = pool_cfg_pkg::MAX_K;
    localparam int NUM_CH = pool_data_pkg::NUM_CH;

    pool_cfg_if u_cfg_if ();
    pool_idx_if u_idx_if ();

    // ==============================
    // Map rows to index stream
    // ==============================
    pool_map_fetch #(
        .IDX_W  (IDX_W),
        .MAX_K  (MAX_K),
        .NUM_CH (NUM_CH)
    ) u_map_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .clr             (clr),
        .cfg_vld         (cfg_vld),
        .cfg_k           (cfg_k),
        .cfg_nip         (cfg_nip),
        .cfg_chi         (cfg_chi),
        .cfg_rdy         (cfg_rdy),
        .map_rd_addr_vld (map_rd_addr_vld),
        .map_rd_addr     (map_rd_addr),
        .map_rd_addr_rdy (map_rd_addr_rdy),
        .map_rd_vld      (map_rd_vld),
        .map_rd_dat      (map_rd_dat),
        .map_rd_rdy      (map_rd_rdy),
        .cfg             (u_cfg_if.cfg_src),
        .idx             (u_idx_if.src)
    );

    // ==============================
    // Index stream to feature reads
    // ==============================
    pool_ofm_gather #(
        .IDX_W (IDX_W)
    ) u_ofm_gather (
        .clk             (clk),
        .rst_n           (rst_n),
        .clr             (clr),
        .cfg             (u_cfg_if.cfg_sink),
        .idx             (u_idx_if.sink),
        .ofm_rd_addr_vld (ofm_rd_addr_vld),
        .ofm_rd_addr     (ofm_rd_addr),
        .ofm_rd_addr_rdy (ofm_rd_addr_rdy)
    );

    // ==============================
    // Feature data to pooled writes
    // ==============================
    pool_max_core #(
        .IDX_W  (IDX_W),
        .MAX_K  (MAX_K),
        .NUM_CH (NUM_CH)
    ) u_max_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .clr         (clr),
        .cfg         (u_cfg_if.cfg_sink),
        .ofm_rd_vld  (ofm_rd_vld),
        .ofm_rd_dat  (ofm_rd_dat),
        .ofm_rd_rdy  (ofm_rd_rdy),
        .ofm_wr_vld  (ofm_wr_vld),
        .ofm_wr_addr (ofm_wr_addr),
        .ofm_wr_dat  (ofm_wr_dat),
        .ofm_wr_rdy  (ofm_wr_rdy)
    );

endmodule

// File: tb_pool_top.sv
// Testbench for the max-pooling unit with GLB models, golden data loader, checks and timeout
module tb_pool_top
    import pool_cfg_pkg::*;
    import pool_data_pkg::*;
();

    localparam int NUM_JOBS = 3;

    // ==============================
    // Golden file regions, one 128-bit row each
    // ==============================
    localparam int JOB_AT  = 'h00;
    localparam int FEAT_AT = 'h10;
    localparam int MAP_AT  = 'h20;
    localparam int EXP_AT  = 'h30;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      clr;
    logic      cfg_vld;
    logic      cfg_rdy;
    pool_k_t   cfg_k;
    pool_idx_t cfg_nip;
    pool_chn_t cfg_chi;
    logic      map_rd_addr_vld;
    pool_idx_t map_rd_addr;
    logic      map_rd_addr_rdy;
    logic      map_rd_vld;
    map_word_u map_rd_dat;
    logic      map_rd_rdy;
    logic      ofm_rd_addr_vld;
    pool_idx_t ofm_rd_addr;
    logic      ofm_rd_addr_rdy;
    logic      ofm_rd_vld;
    act_vec_t  ofm_rd_dat;
    logic      ofm_rd_rdy;
    logic      ofm_wr_vld;
    pool_idx_t ofm_wr_addr;
    act_vec_t  ofm_wr_dat;
    logic      ofm_wr_rdy;

    logic [127:0] gold [0:63];
    // Read data owed by the GLB, oldest first
    map_word_u    map_q [$];
    act_vec_t     feat_q [$];
    integer       seed = 32'h25867f4d;
    logic         stall = 1'b0;
    int           cur_map_base;
    int           cur_exp_base;
    int           cur_count;
    int           wr_seen = 0;
    int           map_req_seen = 0;
    int           cycles = 0;
    int           limit = 0;
    int           total_reads;

    always #2 clk = ~clk;

    pool_top u_pool_top (.*);

    // ==============================
    // Checks
    // ==============================
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Stopped on first failure");
    endtask

    task automatic check_idx(input string name, input pool_idx_t exp, input pool_idx_t act);
        if (act !== exp) begin
            $display("ERR at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "Index mismatch");
        end
    endtask

    task automatic check_vec(input string name, input act_vec_t exp, input act_vec_t act);
        if (act !== exp) begin
            $display("ERR at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "Data mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR at %0t: %s expected %b, got %b", $time, name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "Control mismatch");
        end
    endtask

    // Idle unit: ready for a job, nothing in flight
    task automatic check_idle();
        check_bit("cfg_rdy", 1'b1, cfg_rdy);
        check_bit("map_rd_addr_vld", 1'b0, map_rd_addr_vld);
        check_bit("ofm_rd_addr_vld", 1'b0, ofm_rd_addr_vld);
        check_bit("ofm_wr_vld", 1'b0, ofm_wr_vld);
    endtask

    // Writes come in address order 0 upward
    task automatic record_write();
        if (wr_seen >= cur_count) begin
            fail_run("A pooled write was accepted after the last expected write of the job");
        end else begin
            check_idx("ofm_wr_addr", pool_idx_t'(wr_seen), ofm_wr_addr);
            check_vec("ofm_wr_dat", act_vec_t'(gold[EXP_AT + cur_exp_base + wr_seen]),
                      ofm_wr_dat);
            wr_seen++;
        end
    endtask

    // ==============================
    // Stimulus helpers
    // ==============================
    function logic ready_draw();
        ready_draw = !stall || (($random(seed) & 3) != 0);
    endfunction

    function logic gap_draw();
        gap_draw = stall && (($random(seed) & 3) == 0);
    endfunction

    // Neighbor slots sit in 16-bit fields of the golden row
    function automatic map_word_u unpack_map(input int row);
        map_word_u w;
        w.raw = '0;
        for (int s = 0; s < MAX_K; s++) begin
            w.nbr[s] = gold[row][16*s +: IDX_WIDTH];
        end
        return w;
    endfunction

    function automatic int job_reads(input int j);
        logic [127:0] rec;
        rec = gold[JOB_AT + j];
        return int'(rec[31:16]) * (int'(rec[15:0]) / NUM_CH) * int'(rec[47:32]);
    endfunction

    // ==============================
    // GLB models
    // ==============================
    always @(posedge clk) begin : glb_model
        logic map_taken;
        logic feat_taken;
        logic clr_edge;
        map_taken  = rst_n && map_rd_vld && map_rd_rdy;
        feat_taken = rst_n && ofm_rd_vld && ofm_rd_rdy;
        clr_edge   = clr;
        // Map rows requested once per point, in point order
        if (rst_n && map_rd_addr_vld && map_rd_addr_rdy) begin
            check_idx("map_rd_addr", pool_idx_t'(map_req_seen), map_rd_addr);
            map_req_seen++;
            map_q.push_back(unpack_map(MAP_AT + cur_map_base + map_rd_addr));
        end
        if (map_taken) begin
            map_q.delete(0);
        end
        if (rst_n && ofm_rd_addr_vld && ofm_rd_addr_rdy) begin
            feat_q.push_back(act_vec_t'(gold[FEAT_AT + ofm_rd_addr]));
        end
        if (feat_taken) begin
            feat_q.delete(0);
        end
        // Writes caught by a clear are dropped by the DUT
        if (rst_n && !clr_edge && ofm_wr_vld && ofm_wr_rdy) begin
            record_write();
        end
        #1;
        if (!rst_n || clr_edge) begin
            map_q.delete();
            feat_q.delete();
            map_taken  = 1'b1;
            feat_taken = 1'b1;
        end
        if (map_taken) begin
            map_rd_vld = 1'b0;
        end
        if (!map_rd_vld && map_q.size() > 0 && !gap_draw()) begin
            map_rd_vld = 1'b1;
            map_rd_dat = map_q[0];
        end
        if (feat_taken) begin
            ofm_rd_vld = 1'b0;
        end
        if (!ofm_rd_vld && feat_q.size() > 0 && !gap_draw()) begin
            ofm_rd_vld = 1'b1;
            ofm_rd_dat = feat_q[0];
        end
        map_rd_addr_rdy = ready_draw();
        ofm_rd_addr_rdy = ready_draw();
        ofm_wr_rdy      = ready_draw();
    end

    // Hang guard
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the run hung, no completion within %0d cycles", limit);
            $display("ERRORS FOUND");
            $fatal(1, "Timeout");
        end
    end

    // ==============================
    // Jobs
    // ==============================
    task automatic start_job(input int j);
        logic [127:0] rec;
        rec          = gold[JOB_AT + j];
        cur_map_base = int'(rec[63:48]);
        cur_exp_base = int'(rec[79:64]);
        cur_count    = int'(rec[95:80]);
        wr_seen      = 0;
        map_req_seen = 0;
        if (cur_count != int'(rec[31:16]) * (int'(rec[15:0]) / NUM_CH)) begin
            fail_run("Golden write count does not match points times channel groups");
        end
        while (gap_draw()) begin
            @(posedge clk);
            #1;
        end
        check_bit("cfg_rdy", 1'b1, cfg_rdy);
        cfg_k   = pool_k_t'(rec[47:32]);
        cfg_nip = pool_idx_t'(rec[31:16]);
        cfg_chi = pool_chn_t'(rec[15:0]);
        cfg_vld = 1'b1;
        @(posedge clk);
        #1;
        cfg_vld = 1'b0;
        // Accepted at that edge, first map request right after
        check_bit("cfg_rdy", 1'b0, cfg_rdy);
        check_bit("map_rd_addr_vld", 1'b1, map_rd_addr_vld);
    endtask

    // Busy until the last write, idle the cycle after
    task automatic finish_job();
        while (wr_seen < cur_count) begin
            check_bit("cfg_rdy", 1'b0, cfg_rdy);
            @(posedge clk);
            #1;
        end
        check_idle();
        // One map row per point
        check_idx("map request count", cfg_nip, pool_idx_t'(map_req_seen));
    endtask

    task automatic run_job(input int j);
        start_job(j);
        finish_job();
    endtask

    initial begin
        rst_n           = 1'b0;
        clr             = 1'b0;
        cfg_vld         = 1'b0;
        cfg_k           = '0;
        cfg_nip         = '0;
        cfg_chi         = '0;
        map_rd_addr_rdy = 1'b0;
        map_rd_vld      = 1'b0;
        map_rd_dat      = '0;
        ofm_rd_addr_rdy = 1'b0;
        ofm_rd_vld      = 1'b0;
        ofm_rd_dat      = '0;
        ofm_wr_rdy      = 1'b0;
        $readmemh("pool_golden.txt", gold);
        if ($isunknown(gold[JOB_AT])) begin
            fail_run("Golden file pool_golden.txt could not be read");
        end
        // Two full passes plus the cleared job and its rerun
        total_reads = 2 * job_reads(NUM_JOBS - 1);
        for (int j = 0; j < NUM_JOBS; j++) begin
            total_reads += 2 * job_reads(j);
        end
        limit = 40 * total_reads + 200;

        repeat (16) begin
            @(posedge clk);
            #1;
            check_idle();
        end
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_idle();

        // Stall-free pass
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end

        // Random gaps on every ready and valid
        stall = 1'b1;
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end

        // Clear in the middle of a job, then the same job again
        start_job(NUM_JOBS - 1);
        while (wr_seen < 2) begin
            @(posedge clk);
            #1;
        end
        clr = 1'b1;
        @(posedge clk);
        #1;
        clr = 1'b0;
        check_idle();
        run_job(NUM_JOBS - 1);

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: pool_golden.txt
// Rows are 128 bits. Jobs at 00: [95:80] writes, [79:64] expected base,
// [63:48] map base, [47:32] k, [31:16] nip, [15:0] channels
@00
00000000000400000000000100020020
00000000000200040002000800020010
00000000000600060004000300030020
// Feature rows by GLB address, lane 15 leftmost
@10
000000000000000000000000000000F0
0101010101010101010101010101F101
02020202020202020202020202F20202
030303030303030303030303F3030303
0404040404040404040404F404040404
05050505050505050505F50505050505
060606060606060606F6060606060606
0707070707070707F707070707070707
08080808080808F80808080808080808
090909090909F9090909090909090909
0A0A0A0A0AFA0A0A0A0A0A0A0A0A0A0A
0B0B0B0BFB0B0B0B0B0B0B0B0B0B0B0B
0C0C0CFC0C0C0C0C0C0C0C0C0C0C0C0C
0D0DFD0D0D0D0D0D0D0D0D0D0D0D0D0D
0EFE0E0E0E0E0E0E0E0E0E0E0E0E0E0E
FF0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F
// Map words, neighbor slot s in bits [16s+9:16s], slot 7 leftmost
@20
00000000000000000000000000070003
00000000000000000000000000010005
00040001000600030000000700020005
000D000B000E000A000C0008000F0009
00000000000000000000000200040001
00000000000000000000000300000007
00000000000000000000000500060006
// Expected pooled words in write order, address is the position in the job
@30
060606060606060606F6060606060606
0707070707070707F707070707070707
0A0A0A0A0AFA0A0A0A0A0A0A0A0A0A0A
0B0B0B0BFB0B0B0B0B0B0B0B0B0B0B0B
0707070707070707F7F6F5F4F3F2F1F0
FFFEFDFCFBFAF9F80F0F0F0F0F0F0F0F
08080808080808F8080808F408F20808
090909090909F9090909F509F3090909
0EFE0E0E0E0E0E0E0EF60E0E0E0E0EF0
FF0F0F0F0F0F0F0FF70F0F0F0F0FF10F
0C0C0CFC0CFA0C0C0C0C0C0C0C0C0C0C
0D0DFD0DFB0D0D0D0D0D0D0D0D0D0D0D

// File: verilog.f
pool_cfg_pkg.sv
pool_data_pkg.sv
pool_if.sv
pool_map_fetch.sv
pool_ofm_gather.sv
pool_max_core.sv
pool_top.sv
tb_pool_top.sv

// File: Bender.yml
package:
  name: pool_unit

sources:
  - pool_cfg_pkg.sv
  - pool_data_pkg.sv
  - pool_if.sv
  - pool_map_fetch.sv
  - pool_ofm_gather.sv
  - pool_max_core.sv
  - pool_top.sv
  - target: test
    files:
      - tb_pool_top.sv
